// ==== hw/uart_frame_pkg.sv ====
`default_nettype none

package uart_frame_pkg;

	// =========================================================================
	// serial framing constants
	// =========================================================================
	localparam int OVERSAMPLE = 16;	// ticks per bit
	localparam int WORD_BYTES = 4;	// frames per bus word

	// parity selection (code 3 behaves as none)
	typedef enum logic [1:0] {
		PAR_NONE = 2'd0,
		PAR_EVEN = 2'd1,
		PAR_ODD  = 2'd2
	} parity_mode_t;

	// =========================================================================
	// CTRL register layout, msb first
	// =========================================================================
	typedef struct packed {
		logic [12:0]  rsvd;		// kept as written
		logic         stop2;	// two stop bits when set
		parity_mode_t parity;
		logic [15:0]  baud_div;	// uart_clk cycles per tick
	} uart_ctrl_t;

	// bus side writes raw, framing logic reads f
	typedef union packed {
		logic [31:0] raw;
		uart_ctrl_t  f;
	} uart_ctrl_u;

endpackage

`default_nettype wire

// ==== hw/axil_map_pkg.sv ====
`default_nettype none

package axil_map_pkg;

	// =========================================================================
	// register map (byte offsets)
	// =========================================================================
	localparam logic [3:0] CTRL_OFS    = 4'h0;	// framing and divisor
	localparam logic [3:0] STATUS_OFS  = 4'h4;	// flags, w1c on error bits
	localparam logic [3:0] RX_DATA_OFS = 4'h8;	// read pops the word
	localparam logic [3:0] TX_DATA_OFS = 4'hC;	// write starts a word

	// AXI response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axil_resp_t;

	// =========================================================================
	// STATUS bit positions
	// =========================================================================
	localparam int ST_RX_VALID   = 0;
	localparam int ST_TX_BUSY    = 1;
	localparam int ST_PARITY_ERR = 2;	// sticky
	localparam int ST_FRAME_ERR  = 3;	// sticky
	localparam int ST_OVERRUN    = 4;	// sticky

endpackage

`default_nettype wire

// ==== hw/uart_baud_tick.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_baud_tick import uart_frame_pkg::*; #(
	parameter int DIV_WIDTH = 16	// counter width, no wider than the CTRL field
) (
	input  logic       uart_clk,
	input  logic       nrst,
	input  uart_ctrl_u ctrl,
	output logic       tick
);

	logic [DIV_WIDTH-1:0] div;		// live divisor
	logic [DIV_WIDTH-1:0] div_q;	// divisor of the running count
	logic [DIV_WIDTH-1:0] cnt;

	assign div = ctrl.f.baud_div[DIV_WIDTH-1:0];

	// one tick every div cycles (every cycle for 0 or 1)
	always_ff @(posedge uart_clk) begin
		if (nrst) begin
			div_q <= '0;
			cnt   <= '0;
			tick  <= 1'b0;
		end else if (div != div_q) begin	// new rate, restart now
			div_q <= div;
			cnt   <= div;
			tick  <= 1'b0;
		end else if (cnt <= DIV_WIDTH'(1)) begin
			cnt  <= div;	// reload
			tick <= 1'b1;
		end else begin
			cnt  <= cnt - 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== hw/uart_rx_frame.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_rx_frame import uart_frame_pkg::*; (
	input  logic       uart_clk,
	input  logic       nrst,
	input  logic       tick,
	input  uart_ctrl_u ctrl,
	input  logic       rxd,
	output logic [7:0] byte_data,
	output logic       byte_valid,
	output logic       parity_bad,
	output logic       frame_bad
);

	localparam int OS_W = $clog2(OVERSAMPLE);
	localparam logic [2:0] S_IDLE  = 3'd0;
	localparam logic [2:0] S_START = 3'd1;
	localparam logic [2:0] S_DATA  = 3'd2;
	localparam logic [2:0] S_PAR   = 3'd3;
	localparam logic [2:0] S_STOP  = 3'd4;

	logic            rx_s1;		// sync stage 1
	logic            rx_s2;		// sync stage 2
	logic            line_q;	// line level at the last tick
	logic [2:0]      state;
	logic [OS_W-1:0] os_cnt;	// ticks within a bit
	logic [2:0]      bit_cnt;
	logic [7:0]      shreg;
	logic            par_bit;	// sampled parity bit
	logic            par_on;
	logic            par_exp;
	logic            bit_end;

	assign par_on  = (ctrl.f.parity == PAR_EVEN) || (ctrl.f.parity == PAR_ODD);
	assign par_exp = (ctrl.f.parity == PAR_ODD) ? ~^shreg : ^shreg;
	assign bit_end = tick && (os_cnt == OS_W'(OVERSAMPLE - 1));	// mid of next bit

	// two-flop synchronizer, idles high
	always_ff @(posedge uart_clk) begin
		if (nrst) begin
			rx_s1 <= 1'b1;
			rx_s2 <= 1'b1;
		end else begin
			rx_s1 <= rxd;
			rx_s2 <= rx_s1;
		end
	end

	// =========================================================================
	// frame FSM
	// =========================================================================
	always_ff @(posedge uart_clk) begin
		if (nrst) begin
			state      <= S_IDLE;
			os_cnt     <= '0;
			bit_cnt    <= '0;
			line_q     <= 1'b1;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= 1'b0;
			if (tick) begin
				line_q <= rx_s2;
				os_cnt <= os_cnt + 1'b1;
			end
			case (state)
				S_IDLE: if (tick && line_q && !rx_s2) begin	// falling edge
					state  <= S_START;
					os_cnt <= '0;
				end
				S_START: if (tick && os_cnt == OS_W'(OVERSAMPLE / 2 - 1)) begin
					os_cnt  <= '0;	// realign to mid-bit
					bit_cnt <= '0;
					state   <= rx_s2 ? S_IDLE : S_DATA;	// high here means a glitch
				end
				S_DATA: if (bit_end) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7)
						state <= par_on ? S_PAR : S_STOP;
				end
				S_PAR: if (bit_end)
					state <= S_STOP;
				S_STOP: if (bit_end) begin	// first stop only
					byte_valid <= 1'b1;
					state      <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// sampled payload
	always_ff @(posedge uart_clk) begin
		if (bit_end) begin
			case (state)
				S_DATA: shreg <= {rx_s2, shreg[7:1]};	// lsb first
				S_PAR:  par_bit <= rx_s2;
				S_STOP: begin
					byte_data  <= shreg;
					parity_bad <= par_on && (par_bit != par_exp);
					frame_bad  <= !rx_s2;	// stop must be high
				end
				default: ;
			endcase
		end
	end

	a_byte_pulse: assert property (@(posedge uart_clk) disable iff (nrst)
		byte_valid |=> !byte_valid);

endmodule

`default_nettype wire

// ==== hw/uart_word_assembler.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_word_assembler import uart_frame_pkg::*, axil_map_pkg::*; (
	input  logic        uart_clk,
	input  logic        nrst,
	input  logic [7:0]  byte_data,
	input  logic        byte_valid,
	input  logic        parity_bad,
	input  logic        frame_bad,
	input  logic        rx_pop,
	input  logic [4:0]  err_clear,
	output logic [31:0] rx_word,
	output logic        rx_valid,
	output logic        parity_err,
	output logic        frame_err,
	output logic        overrun
);

	localparam int CNT_W = $clog2(WORD_BYTES + 1);

	logic [CNT_W-1:0]              byte_cnt;	// next byte slot
	logic [8*(WORD_BYTES-1)-1:0]   acc;			// lower bytes of the word
	logic                          last_byte;

	assign last_byte = byte_valid && (byte_cnt == CNT_W'(WORD_BYTES - 1));

	always_ff @(posedge uart_clk) begin
		if (nrst)
			byte_cnt <= '0;
		else if (byte_valid)
			byte_cnt <= last_byte ? '0 : byte_cnt + 1'b1;
	end

	// low byte first, top byte goes straight to the holding register
	always_ff @(posedge uart_clk) begin
		if (byte_valid && !last_byte)
			acc[8*byte_cnt +: 8] <= byte_data;
		if (last_byte)
			rx_word <= {byte_data, acc};	// overwrites an unread word
	end

	// =========================================================================
	// valid and sticky flags
	// =========================================================================
	always_ff @(posedge uart_clk) begin
		if (nrst) begin
			rx_valid   <= 1'b0;
			parity_err <= 1'b0;
			frame_err  <= 1'b0;
			overrun    <= 1'b0;
		end else begin
			if (last_byte)
				rx_valid <= 1'b1;
			else if (rx_pop)
				rx_valid <= 1'b0;
			// a new error beats a clear in the same cycle
			if (byte_valid && parity_bad)
				parity_err <= 1'b1;
			else if (err_clear[ST_PARITY_ERR])
				parity_err <= 1'b0;
			if (byte_valid && frame_bad)
				frame_err <= 1'b1;
			else if (err_clear[ST_FRAME_ERR])
				frame_err <= 1'b0;
			if (last_byte && rx_valid && !rx_pop)	// old word never read
				overrun <= 1'b1;
			else if (err_clear[ST_OVERRUN])
				overrun <= 1'b0;
		end
	end

	a_cnt_range: assert property (@(posedge uart_clk) disable iff (nrst)
		byte_cnt <= CNT_W'(WORD_BYTES - 1));

endmodule

`default_nettype wire

// ==== hw/uart_tx_frame.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_tx_frame import uart_frame_pkg::*; (
	input  logic        uart_clk,
	input  logic        nrst,
	input  logic        tick,
	input  uart_ctrl_u  ctrl,
	input  logic [31:0] tx_word,
	input  logic        tx_start,
	output logic        txd,
	output logic        tx_busy
);

	localparam int OS_W = $clog2(OVERSAMPLE);
	localparam logic [2:0] S_IDLE  = 3'd0;
	localparam logic [2:0] S_START = 3'd1;
	localparam logic [2:0] S_DATA  = 3'd2;
	localparam logic [2:0] S_PAR   = 3'd3;
	localparam logic [2:0] S_STOP  = 3'd4;

	logic [2:0]      state;
	logic [OS_W-1:0] os_cnt;
	logic [2:0]      bit_cnt;
	logic [1:0]      byte_cnt;	// frame within the word
	logic            stop_cnt;	// second stop pending
	logic [31:0]     word_q;	// bytes not yet sent, low first
	logic [7:0]      shreg;
	logic            par_q;
	logic            par_on;
	logic            bit_end;

	assign par_on  = (ctrl.f.parity == PAR_EVEN) || (ctrl.f.parity == PAR_ODD);
	assign bit_end = tick && (os_cnt == OS_W'(OVERSAMPLE - 1));

	// =========================================================================
	// bit sequencer
	// =========================================================================
	always_ff @(posedge uart_clk) begin
		if (nrst) begin
			state    <= S_IDLE;
			tx_busy  <= 1'b0;
			os_cnt   <= '0;
			bit_cnt  <= '0;
			byte_cnt <= '0;
			stop_cnt <= 1'b0;
		end else begin
			if (tick)
				os_cnt <= os_cnt + 1'b1;
			case (state)
				S_IDLE: if (tx_start) begin
					state    <= S_START;
					tx_busy  <= 1'b1;
					os_cnt   <= '0;	// full-length start bit
					byte_cnt <= '0;
				end
				S_START: if (bit_end) begin
					state    <= S_DATA;
					bit_cnt  <= '0;
					stop_cnt <= 1'b0;
				end
				S_DATA: if (bit_end) begin
					bit_cnt <= bit_cnt + 1'b1;
					if (bit_cnt == 3'd7)
						state <= par_on ? S_PAR : S_STOP;
				end
				S_PAR: if (bit_end)
					state <= S_STOP;
				S_STOP: if (bit_end) begin
					if (ctrl.f.stop2 && !stop_cnt)
						stop_cnt <= 1'b1;	// one more stop bit
					else if (byte_cnt == 2'(WORD_BYTES - 1)) begin
						state   <= S_IDLE;	// word done
						tx_busy <= 1'b0;
					end else begin
						byte_cnt <= byte_cnt + 1'b1;
						state    <= S_START;
					end
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// word and byte shifters
	always_ff @(posedge uart_clk) begin
		if (state == S_IDLE && tx_start)
			word_q <= tx_word;
		else if (state == S_START && bit_end) begin
			shreg  <= word_q[7:0];
			par_q  <= (ctrl.f.parity == PAR_ODD) ? ~^word_q[7:0] : ^word_q[7:0];
			word_q <= {8'h00, word_q[31:8]};	// next byte down
		end else if (state == S_DATA && bit_end)
			shreg <= {1'b0, shreg[7:1]};
	end

	always_comb begin
		case (state)
			S_START: txd = 1'b0;
			S_DATA:  txd = shreg[0];
			S_PAR:   txd = par_q;
			default: txd = 1'b1;	// idle and stop
		endcase
	end

	a_no_restart: assert property (@(posedge uart_clk) disable iff (nrst)
		tx_start |-> !tx_busy);

endmodule

`default_nettype wire

// ==== hw/uart_axil_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_axil_regs import uart_frame_pkg::*, axil_map_pkg::*; #(
	parameter int RESET_DIV = 54
) (
	input  logic        uart_clk,
	input  logic        nrst,
	input  logic [3:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [3:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	input  logic [31:0] rx_word,
	input  logic        rx_valid,
	input  logic        parity_err,
	input  logic        frame_err,
	input  logic        overrun,
	input  logic        tx_busy,
	output uart_ctrl_u  ctrl,
	output logic [31:0] tx_word,
	output logic        tx_start,
	output logic        rx_pop,
	output logic [4:0]  err_clear
);

	logic        wr_hs;		// AW and W taken together
	logic        rd_hs;
	axil_resp_t  wr_resp;
	axil_resp_t  rd_resp;
	logic [31:0] rd_data;
	logic [31:0] status;
	logic [31:0] ctrl_wr;	// CTRL after byte strobes

	assign wr_hs   = awvalid && wvalid && !bvalid;
	assign awready = wr_hs;
	assign wready  = wr_hs;
	assign arready = !rvalid;	// one read in flight
	assign rd_hs   = arvalid && arready;

	assign rx_pop    = rd_hs && (araddr == RX_DATA_OFS);
	assign err_clear = (wr_hs && awaddr == STATUS_OFS) ? wdata[4:0] : 5'd0;	// w1c mask

	always_comb begin
		status                = '0;
		status[ST_RX_VALID]   = rx_valid;
		status[ST_TX_BUSY]    = tx_busy;
		status[ST_PARITY_ERR] = parity_err;
		status[ST_FRAME_ERR]  = frame_err;
		status[ST_OVERRUN]    = overrun;
	end

	always_comb begin
		for (int i = 0; i < 4; i++)
			ctrl_wr[8*i +: 8] = wstrb[i] ? wdata[8*i +: 8] : ctrl.raw[8*i +: 8];
	end

	// =========================================================================
	// address decode, unaligned offsets fall to default
	// =========================================================================
	always_comb begin
		case (awaddr)
			CTRL_OFS,
			STATUS_OFS:  wr_resp = OKAY;
			RX_DATA_OFS: wr_resp = SLVERR;	// read only
			TX_DATA_OFS: wr_resp = (tx_busy || tx_start) ? SLVERR : OKAY;	// word in flight
			default:     wr_resp = DECERR;
		endcase
	end

	always_comb begin
		rd_resp = OKAY;
		case (araddr)
			CTRL_OFS:    rd_data = ctrl.raw;
			STATUS_OFS:  rd_data = status;
			RX_DATA_OFS: rd_data = rx_word;
			TX_DATA_OFS: rd_data = tx_word;	// last word sent
			default: begin
				rd_data = '0;
				rd_resp = DECERR;
			end
		endcase
	end

	// channel state and CTRL
	always_ff @(posedge uart_clk) begin
		if (nrst) begin
			bvalid          <= 1'b0;
			rvalid          <= 1'b0;
			tx_start        <= 1'b0;
			ctrl.f.rsvd     <= '0;
			ctrl.f.stop2    <= 1'b0;	// one stop bit
			ctrl.f.parity   <= PAR_EVEN;
			ctrl.f.baud_div <= 16'(RESET_DIV);
		end else begin
			tx_start <= wr_hs && (awaddr == TX_DATA_OFS) && (wr_resp == OKAY);
			if (wr_hs)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;
			if (rd_hs)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
			if (wr_hs && awaddr == CTRL_OFS)
				ctrl.raw <= ctrl_wr;
		end
	end

	// response and data payload
	always_ff @(posedge uart_clk) begin
		if (wr_hs)
			bresp <= wr_resp;
		if (wr_hs && awaddr == TX_DATA_OFS && wr_resp == OKAY)
			tx_word <= wdata;
		if (rd_hs) begin
			rdata <= rd_data;
			rresp <= rd_resp;
		end
	end

	a_bvalid_hold: assert property (@(posedge uart_clk) disable iff (nrst)
		bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

`default_nettype wire

// ==== hw/uart_word_link.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart_word_link import uart_frame_pkg::*; #(
	parameter int DIV_WIDTH = 16,	// baud counter width
	parameter int RESET_DIV = 54	// CTRL divisor out of reset
) (
	input  logic        uart_clk,
	input  logic        nrst,
	input  logic [3:0]  awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [31:0] wdata,
	input  logic [3:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [3:0]  araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [31:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready,
	input  logic        rxd,
	output logic        txd
);

	// =========================================================================
	// internal nets
	// =========================================================================
	uart_ctrl_u  ctrl;
	logic        tick;
	logic [31:0] tx_word;
	logic        tx_start;
	logic        tx_busy;
	logic        rx_pop;
	logic [4:0]  err_clear;
	logic [7:0]  byte_data;
	logic        byte_valid;
	logic        parity_bad;
	logic        frame_bad;
	logic [31:0] rx_word;
	logic        rx_valid;
	logic        parity_err;
	logic        frame_err;
	logic        overrun;

	uart_axil_regs #(.RESET_DIV(RESET_DIV)) uart_axil_regs_i (
		.uart_clk, .nrst,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.rx_word, .rx_valid, .parity_err, .frame_err, .overrun, .tx_busy,
		.ctrl, .tx_word, .tx_start, .rx_pop, .err_clear
	);

	uart_baud_tick #(.DIV_WIDTH(DIV_WIDTH)) uart_baud_tick_i (
		.uart_clk, .nrst, .ctrl, .tick
	);

	// receive path
	uart_rx_frame uart_rx_frame_i (
		.uart_clk, .nrst, .tick, .ctrl, .rxd,
		.byte_data, .byte_valid, .parity_bad, .frame_bad
	);

	uart_word_assembler uart_word_assembler_i (
		.uart_clk, .nrst, .byte_data, .byte_valid, .parity_bad, .frame_bad,
		.rx_pop, .err_clear,
		.rx_word, .rx_valid, .parity_err, .frame_err, .overrun
	);

	// transmit path
	uart_tx_frame uart_tx_frame_i (
		.uart_clk, .nrst, .tick, .ctrl, .tx_word, .tx_start, .txd, .tx_busy
	);

endmodule

`default_nettype wire

// ==== test/tb_uart_word_link.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_uart_word_link import uart_frame_pkg::*, axil_map_pkg::*;;

	localparam int CLK_NS    = 8;
	localparam int RESET_DIV = 2;	// short frames
	localparam int MAX_DIV   = 3;	// largest divisor used by any test
	localparam int FRAME_CYC = 12 * OVERSAMPLE * MAX_DIV;	// longest frame
	localparam int FRAMES    = 30;	// rx + tx frames + idle gaps
	localparam int WATCHDOG_NS = 2 * FRAMES * FRAME_CYC * CLK_NS + 20000;
	localparam int POLL_MAX  = 2000;	// STATUS reads before giving up
	localparam int HS_MAX    = 100;		// cycles to wait for a handshake

	logic        uart_clk;
	logic        nrst;
	logic [3:0]  awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [3:0]  araddr;
	logic        arvalid;
	logic        arready;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rvalid;
	logic        rready;
	logic        rxd;
	logic        txd;

	int           errors;
	int           test_base;	// errors before the current test
	int           tests;
	int           failed;
	integer       seed;
	int           cur_div;		// framing last written to CTRL
	parity_mode_t cur_par;
	logic         cur_stop2;
	logic [7:0]   tx_seen[$];	// bytes decoded on txd

	uart_word_link #(.DIV_WIDTH(16), .RESET_DIV(RESET_DIV)) uart_word_link_i (
		.uart_clk, .nrst,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.rxd, .txd
	);

	always #(CLK_NS / 2) uart_clk = ~uart_clk;

	// =========================================================================
	// bus timing checks
	// =========================================================================
	a_wr_resp: assert property (@(posedge uart_clk) disable iff (nrst)
		awvalid && awready |=> bvalid)
		else begin
			errors++;
			$display("error %0t: write response not one cycle after acceptance", $time);
		end

	a_rd_resp: assert property (@(posedge uart_clk) disable iff (nrst)
		arvalid && arready |=> rvalid)
		else begin
			errors++;
			$display("error %0t: read response not one cycle after acceptance", $time);
		end

	task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else begin
			errors++;
			$display("error %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	// uart parity bit for a byte
	function automatic logic parity_of(input logic [7:0] d, input parity_mode_t m);
		return (m == PAR_ODD) ? ~^d : ^d;
	endfunction

	// CTRL word: divisor low, parity at 17:16, stop2 at 18
	function automatic logic [31:0] ctrl_word(input int div, input parity_mode_t m,
			input logic two_stop);
		return {13'd0, two_stop, 2'(m), 16'(div)};
	endfunction

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		int n;
		n = 0;
		@(negedge uart_clk);
		awaddr  = addr;
		wdata   = data;
		wstrb   = 4'hF;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		do begin
			@(posedge uart_clk);
			n++;
		end while (!(awready && wready) && n < HS_MAX);
		if (n >= HS_MAX) begin
			errors++;
			$display("%0t: write to %h was never accepted", $time, addr);
		end
		@(negedge uart_clk);
		awvalid = 1'b0;
		wvalid  = 1'b0;
		n = 0;
		do begin
			@(posedge uart_clk);
			n++;
		end while (!bvalid && n < HS_MAX);	// response follows acceptance
		resp = bresp;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		n = 0;
		@(negedge uart_clk);
		araddr  = addr;
		arvalid = 1'b1;
		do begin
			@(posedge uart_clk);
			n++;
		end while (!arready && n < HS_MAX);
		if (n >= HS_MAX) begin
			errors++;
			$display("%0t: read of %h was never accepted", $time, addr);
		end
		@(negedge uart_clk);
		arvalid = 1'b0;
		n = 0;
		do begin
			@(posedge uart_clk);
			n++;
		end while (!rvalid && n < HS_MAX);
		data = rdata;
		resp = rresp;
	endtask

	// =========================================================================
	// serial side
	// =========================================================================
	task automatic send_frame(input logic [7:0] d, input parity_mode_t m,
			input logic two_stop, input logic bad_par);
		int bit_cyc;
		bit_cyc = OVERSAMPLE * cur_div;
		@(negedge uart_clk);
		rxd = 1'b0;	// start
		repeat (bit_cyc) @(negedge uart_clk);
		for (int i = 0; i < 8; i++) begin
			rxd = d[i];	// lsb first
			repeat (bit_cyc) @(negedge uart_clk);
		end
		if (m == PAR_EVEN || m == PAR_ODD) begin
			rxd = parity_of(d, m) ^ bad_par;
			repeat (bit_cyc) @(negedge uart_clk);
		end
		rxd = 1'b1;
		repeat (two_stop ? 2 * bit_cyc : bit_cyc) @(negedge uart_clk);
	endtask

	task automatic send_word(input logic [31:0] w, input parity_mode_t m,
			input logic two_stop, input int bad_byte);
		for (int i = 0; i < WORD_BYTES; i++)
			send_frame(w[8*i +: 8], m, two_stop, i == bad_byte);
	endtask

	// polls STATUS until one bit reaches a level
	task automatic wait_status(input int pos, input logic val, input string what);
		logic [31:0] d;
		logic [1:0]  r;
		int          n;
		n = 0;
		do begin
			axi_read(STATUS_OFS, d, r);
			n++;
		end while (d[pos] !== val && n < POLL_MAX);
		if (d[pos] !== val) begin
			errors++;
			$display("%0t: gave up waiting for %s", $time, what);
		end
	endtask

	task automatic expect_tx_word(input logic [31:0] w);
		expect_eq("txd frame count", tx_seen.size(), WORD_BYTES);
		if (tx_seen.size() == WORD_BYTES)
			for (int i = 0; i < WORD_BYTES; i++)
				expect_eq("txd byte", tx_seen[i], w[8*i +: 8]);
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors == test_base)
			$display("test %s: passed", name);
		else begin
			failed++;
			$display("test %s: failed with %0d errors", name, errors - test_base);
		end
		test_base = errors;
	endtask

	// txd decoder, samples mid-bit on falling clock edges
	initial begin : txd_monitor
		int         bit_cyc;
		logic [7:0] b;
		@(negedge nrst);
		forever begin
			@(negedge txd);
			bit_cyc = OVERSAMPLE * cur_div;
			repeat (bit_cyc / 2) @(negedge uart_clk);
			expect_eq("txd start bit", txd, 1'b0);
			for (int i = 0; i < 8; i++) begin
				repeat (bit_cyc) @(negedge uart_clk);
				b[i] = txd;
			end
			if (cur_par == PAR_EVEN || cur_par == PAR_ODD) begin
				repeat (bit_cyc) @(negedge uart_clk);
				expect_eq("txd parity bit", txd, parity_of(b, cur_par));
			end
			for (int s = 0; s < (cur_stop2 ? 2 : 1); s++) begin
				repeat (bit_cyc) @(negedge uart_clk);
				expect_eq("txd stop bit", txd, 1'b1);
			end
			tx_seen.push_back(b);
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
		$display("Done: errors found");
		$finish;
	end

	// =========================================================================
	// test sequence
	// =========================================================================
	initial begin : main
		logic [31:0] d;
		logic [31:0] w;
		logic [31:0] w2;
		logic [1:0]  r;
		uart_clk  = 1'b0;
		nrst      = 1'b1;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = '0;
		wvalid    = 1'b0;
		bready    = 1'b1;
		araddr    = '0;
		arvalid   = 1'b0;
		rready    = 1'b1;
		rxd       = 1'b1;	// line idle
		errors    = 0;
		test_base = 0;
		tests     = 0;
		failed    = 0;
		seed      = 32'h7625_5da6;
		cur_div   = RESET_DIV;
		cur_par   = PAR_EVEN;
		cur_stop2 = 1'b0;
		repeat (2) @(negedge uart_clk);
		nrst = 1'b0;

		// reset state
		@(negedge uart_clk);
		expect_eq("txd after reset", txd, 1'b1);
		axi_read(STATUS_OFS, d, r);
		expect_eq("STATUS after reset", d, 32'd0);
		expect_eq("STATUS rresp", r, OKAY);
		axi_read(CTRL_OFS, d, r);
		expect_eq("CTRL after reset", d, ctrl_word(RESET_DIV, PAR_EVEN, 1'b0));
		end_test("reset");

		// write response waits for bready
		@(negedge uart_clk);
		bready = 1'b0;
		axi_write(CTRL_OFS, ctrl_word(RESET_DIV, PAR_EVEN, 1'b0), r);	// same framing
		repeat (3) @(negedge uart_clk);
		expect_eq("bvalid without bready", bvalid, 1'b1);
		expect_eq("bresp without bready", bresp, OKAY);
		bready = 1'b1;
		@(negedge uart_clk);
		expect_eq("bvalid after bready", bvalid, 1'b0);
		end_test("write hold");

		// plain receive
		w = $random(seed);
		send_word(w, PAR_EVEN, 1'b0, -1);
		wait_status(ST_RX_VALID, 1'b1, "rx_valid");
		axi_read(STATUS_OFS, d, r);
		expect_eq("STATUS with word", d, 32'd1 << ST_RX_VALID);
		axi_read(RX_DATA_OFS, d, r);
		expect_eq("RX_DATA", d, w);
		axi_read(STATUS_OFS, d, r);
		expect_eq("STATUS after pop", d, 32'd0);
		end_test("receive");

		// parity error on byte 2, word still counts
		w = $random(seed);
		send_word(w, PAR_EVEN, 1'b0, 2);
		wait_status(ST_RX_VALID, 1'b1, "rx_valid");
		axi_read(STATUS_OFS, d, r);
		expect_eq("STATUS parity", d, (32'd1 << ST_RX_VALID) | (32'd1 << ST_PARITY_ERR));
		axi_read(RX_DATA_OFS, d, r);
		expect_eq("RX_DATA bad parity", d, w);
		axi_write(STATUS_OFS, 32'd1 << ST_PARITY_ERR, r);
		expect_eq("STATUS bresp", r, OKAY);
		axi_read(STATUS_OFS, d, r);
		expect_eq("STATUS after w1c", d, 32'd0);
		end_test("parity error");

		// two words, no read in between
		w  = $random(seed);
		w2 = $random(seed);
		send_word(w, PAR_EVEN, 1'b0, -1);
		send_word(w2, PAR_EVEN, 1'b0, -1);
		wait_status(ST_RX_VALID, 1'b1, "rx_valid");
		axi_read(STATUS_OFS, d, r);
		expect_eq("STATUS overrun", d, (32'd1 << ST_RX_VALID) | (32'd1 << ST_OVERRUN));
		axi_read(RX_DATA_OFS, d, r);
		expect_eq("RX_DATA after overrun", d, w2);
		axi_write(STATUS_OFS, 32'd1 << ST_OVERRUN, r);
		axi_read(STATUS_OFS, d, r);
		expect_eq("STATUS after w1c", d, 32'd0);
		end_test("overrun");

		// transmit, plus a rejected write while busy
		tx_seen.delete();
		w  = $random(seed);
		w2 = $random(seed);
		axi_write(TX_DATA_OFS, w, r);
		expect_eq("TX_DATA bresp", r, OKAY);
		wait_status(ST_TX_BUSY, 1'b1, "tx_busy high");
		axi_write(TX_DATA_OFS, w2, r);
		expect_eq("TX_DATA bresp while busy", r, SLVERR);
		wait_status(ST_TX_BUSY, 1'b0, "tx_busy low");
		repeat (12 * OVERSAMPLE * cur_div) @(negedge uart_clk);	// room for a stray frame
		expect_tx_word(w);
		end_test("transmit");

		// odd parity, two stops, divisor 3
		axi_write(CTRL_OFS, ctrl_word(MAX_DIV, PAR_ODD, 1'b1), r);
		expect_eq("CTRL bresp", r, OKAY);
		cur_div   = MAX_DIV;
		cur_par   = PAR_ODD;
		cur_stop2 = 1'b1;
		axi_read(CTRL_OFS, d, r);
		expect_eq("CTRL readback", d, ctrl_word(MAX_DIV, PAR_ODD, 1'b1));
		w = $random(seed);
		send_word(w, PAR_ODD, 1'b1, -1);
		wait_status(ST_RX_VALID, 1'b1, "rx_valid");
		axi_read(STATUS_OFS, d, r);
		expect_eq("STATUS new framing", d, 32'd1 << ST_RX_VALID);
		axi_read(RX_DATA_OFS, d, r);
		expect_eq("RX_DATA new framing", d, w);
		tx_seen.delete();
		w2 = $random(seed);
		axi_write(TX_DATA_OFS, w2, r);
		expect_eq("TX_DATA bresp", r, OKAY);
		wait_status(ST_TX_BUSY, 1'b1, "tx_busy high");
		wait_status(ST_TX_BUSY, 1'b0, "tx_busy low");
		expect_tx_word(w2);
		axi_read(4'h2, d, r);	// unaligned
		expect_eq("unaligned rresp", r, DECERR);
		axi_write(4'h5, 32'hFFFF_FFFF, r);
		expect_eq("unaligned bresp", r, DECERR);
		end_test("reconfigure");

		$display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
hw/uart_frame_pkg.sv
hw/axil_map_pkg.sv
hw/uart_baud_tick.sv
hw/uart_rx_frame.sv
hw/uart_word_assembler.sv
hw/uart_tx_frame.sv
hw/uart_axil_regs.sv
hw/uart_word_link.sv
test/tb_uart_word_link.sv
